/* src/bridge_bus_pkg.sv */
package bridge_bus_pkg;

    // Word address width of the host register window
    localparam int WB_ADR_WIDTH = 2;

    typedef enum logic [WB_ADR_WIDTH-1:0] {
        REG_DATA   = 2'd0,  // Write launches a transfer
        REG_STATUS = 2'd1,  // Busy and overflow flags
        REG_COUNT  = 2'd2,  // Number of accepted words
        REG_CTRL   = 2'd3   // Bit 0 clears overflow
    } reg_addr_e;

    localparam int STATUS_BUSY_BIT = 0;  // Set while a word is in flight to rx_clk
    localparam int STATUS_OVF_BIT  = 1;  // Sticky flag for a data write dropped while busy

endpackage

/* src/bridge_link_pkg.sv */
package bridge_link_pkg;

    // Flops in each synchronizer chain of the crossing
    localparam int SYNC_STAGES = 2;

    typedef enum logic {
        MBOX_IDLE,     // Mailbox free, next data write is accepted
        MBOX_WAIT_ACK  // Word held until the crossing acknowledges it
    } mbox_state_e;

    typedef enum logic {
        RX_EMPTY,  // Holding register free
        RX_FULL    // Holding register offers a word downstream
    } rx_state_e;

endpackage

/* src/wb_mailbox_regs.sv */
`timescale 1ns/1ns

module wb_mailbox_regs #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                    tx_clk,
    input  logic                                    rst_n,
    input  logic                                    wb_cyc,
    input  logic                                    wb_stb,
    input  logic                                    wb_we,
    input  logic [bridge_bus_pkg::WB_ADR_WIDTH-1:0] wb_adr,
    input  logic [31:0]                             wb_dat_w,
    output logic                                    wb_ack,
    output logic [31:0]                             wb_dat_r,
    output logic                                    tx_valid,
    output logic [DATA_WIDTH-1:0]                   data_in,
    input  logic                                    tx_ready
);

    bridge_link_pkg::mbox_state_e mbox_state;
    bridge_bus_pkg::reg_addr_e    reg_sel;

    logic                  req_seen;
    logic                  data_wr;
    logic                  ctrl_wr;
    logic                  launch;
    logic                  drop;
    logic                  overflow;
    logic [31:0]           word_count;
    logic [31:0]           rd_data;
    logic [DATA_WIDTH-1:0] held_word;

    assign reg_sel = bridge_bus_pkg::reg_addr_e'(wb_adr);
    assign data_wr = req_seen && wb_we && (reg_sel == bridge_bus_pkg::REG_DATA);
    assign ctrl_wr = req_seen && wb_we && (reg_sel == bridge_bus_pkg::REG_CTRL);
    assign launch  = data_wr && (mbox_state == bridge_link_pkg::MBOX_IDLE);
    assign drop    = data_wr && (mbox_state == bridge_link_pkg::MBOX_WAIT_ACK);

    // The request is registered once before the ack, so every access costs one idle cycle
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            req_seen <= 1'b0;
            wb_ack   <= 1'b0;
        end else begin
            req_seen <= wb_cyc && wb_stb && !req_seen && !wb_ack;
            wb_ack   <= req_seen;
        end
    end

    always_comb begin
        rd_data = '0;
        case (reg_sel)
            bridge_bus_pkg::REG_STATUS: begin
                rd_data[bridge_bus_pkg::STATUS_BUSY_BIT] = tx_valid;
                rd_data[bridge_bus_pkg::STATUS_OVF_BIT]  = overflow;
            end
            bridge_bus_pkg::REG_COUNT: begin
                rd_data = word_count;
            end
            default: begin
                rd_data = '0;  // Data and control read back as zero
            end
        endcase
    end

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_dat_r <= '0;
        end else if (req_seen && !wb_we) begin
            wb_dat_r <= rd_data;  // Presented together with the ack
        end
    end

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            mbox_state <= bridge_link_pkg::MBOX_IDLE;
            word_count <= '0;
        end else begin
            case (mbox_state)
                bridge_link_pkg::MBOX_IDLE: begin
                    if (launch) begin
                        mbox_state <= bridge_link_pkg::MBOX_WAIT_ACK;
                        word_count <= word_count + 32'd1;
                    end
                end
                bridge_link_pkg::MBOX_WAIT_ACK: begin
                    if (tx_ready) begin
                        mbox_state <= bridge_link_pkg::MBOX_IDLE;  // Word has reached rx_clk
                    end
                end
                default: begin
                    mbox_state <= bridge_link_pkg::MBOX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (drop) begin
            overflow <= 1'b1;  // Late write is discarded, the held word stays
        end else if (ctrl_wr && wb_dat_w[0]) begin
            overflow <= 1'b0;
        end
    end

    always_ff @(posedge tx_clk) begin
        if (launch) begin
            held_word <= wb_dat_w[DATA_WIDTH-1:0];
        end
    end

    assign tx_valid = (mbox_state == bridge_link_pkg::MBOX_WAIT_ACK);
    assign data_in  = held_word;

    // The rx side samples data_in some cycles after the request, so it must not move meanwhile
    a_word_stable: assert property (@(posedge tx_clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> $stable(data_in))
        else $error("mailbox word changed while its transfer was open");

endmodule

/* src/cdc_handshake.sv */
`timescale 1ns/1ns

module cdc_handshake #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  rst_n,
    input  logic                  tx_clk,
    input  logic                  rx_clk,
    input  logic                  tx_valid,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic                  tx_ready,
    output logic                  rx_valid,
    input  logic                  rx_ready,
    output logic [DATA_WIDTH-1:0] data_out
);

    localparam int SYNC_MSB = bridge_link_pkg::SYNC_STAGES - 1;

    bridge_link_pkg::rx_state_e rx_state;

    logic                  tx_valid_d;
    logic                  req_level;
    logic [SYNC_MSB:0]     req_sync;
    logic                  req_sync_d;
    logic                  req_edge;
    logic                  ack_level;
    logic [SYNC_MSB:0]     ack_sync;
    logic                  ack_sync_d;
    logic [DATA_WIDTH-1:0] hold_word;

    // Only the rising edge of tx_valid opens a transfer, so a long valid counts once
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid_d <= 1'b0;
            req_level  <= 1'b0;
        end else begin
            tx_valid_d <= tx_valid;
            if (tx_valid && !tx_valid_d) begin
                req_level <= ~req_level;
            end
        end
    end

    always_ff @(posedge rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            req_sync   <= '0;
            req_sync_d <= 1'b0;
        end else begin
            req_sync   <= {req_sync[SYNC_MSB-1:0], req_level};
            req_sync_d <= req_sync[SYNC_MSB];
        end
    end

    assign req_edge = req_sync[SYNC_MSB] ^ req_sync_d;  // Either toggle direction is a new word

    always_ff @(posedge rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_state  <= bridge_link_pkg::RX_EMPTY;
            ack_level <= 1'b0;
        end else begin
            case (rx_state)
                bridge_link_pkg::RX_EMPTY: begin
                    if (req_edge) begin
                        rx_state <= bridge_link_pkg::RX_FULL;
                    end
                end
                bridge_link_pkg::RX_FULL: begin
                    if (rx_ready) begin
                        rx_state  <= bridge_link_pkg::RX_EMPTY;
                        ack_level <= ~ack_level;  // Acknowledge only once the word is taken
                    end
                end
                default: begin
                    rx_state <= bridge_link_pkg::RX_EMPTY;
                end
            endcase
        end
    end

    // data_in has been stable since before the request toggled, so it is safe to sample here
    always_ff @(posedge rx_clk) begin
        if (req_edge && (rx_state == bridge_link_pkg::RX_EMPTY)) begin
            hold_word <= data_in;
        end
    end

    assign rx_valid = (rx_state == bridge_link_pkg::RX_FULL);
    assign data_out = hold_word;

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_sync   <= '0;
            ack_sync_d <= 1'b0;
        end else begin
            ack_sync   <= {ack_sync[SYNC_MSB-1:0], ack_level};
            ack_sync_d <= ack_sync[SYNC_MSB];
        end
    end

    assign tx_ready = ack_sync[SYNC_MSB] ^ ack_sync_d;

    a_ack_needs_valid: assert property (@(posedge tx_clk) disable iff (!rst_n)
        tx_ready |-> tx_valid)
        else $error("acknowledge arrived with no transfer open");

endmodule

/* src/rx_word_fifo.sv */
`timescale 1ns/1ns

module rx_word_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  rx_clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [DATA_WIDTH-1:0] in_data,
    output logic                  in_ready,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    input  logic                  out_ready
);

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

    logic [ADDR_WIDTH:0] wr_ptr;  // Extra top bit tells full from empty
    logic [ADDR_WIDTH:0] rd_ptr;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[ADDR_WIDTH-1:0]];

    always_ff @(posedge rx_clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_data;
        end
    end

    always_ff @(posedge rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Pop may share a cycle with push, the read side only sees its own pointer
    always_ff @(posedge rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_no_push_full: assert property (@(posedge rx_clk) disable iff (!rst_n)
        full |=> wr_ptr == $past(wr_ptr))
        else $error("write pointer advanced while the FIFO was full");

    a_no_pop_empty: assert property (@(posedge rx_clk) disable iff (!rst_n)
        empty |=> rd_ptr == $past(rd_ptr))
        else $error("read pointer advanced while the FIFO was empty");

endmodule

/* src/mailbox_bridge_top.sv */
`timescale 1ns/1ns

module mailbox_bridge_top #(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                    tx_clk,
    input  logic                                    rx_clk,
    input  logic                                    rst_n,
    input  logic                                    wb_cyc,
    input  logic                                    wb_stb,
    input  logic                                    wb_we,
    input  logic [bridge_bus_pkg::WB_ADR_WIDTH-1:0] wb_adr,
    input  logic [31:0]                             wb_dat_w,
    output logic                                    wb_ack,
    output logic [31:0]                             wb_dat_r,
    output logic                                    out_valid,
    output logic [DATA_WIDTH-1:0]                   out_data,
    input  logic                                    out_ready
);

    logic                  tx_valid;
    logic                  tx_ready;
    logic [DATA_WIDTH-1:0] tx_data;
    logic                  rx_valid;
    logic                  rx_ready;
    logic [DATA_WIDTH-1:0] rx_data;

    wb_mailbox_regs #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_regs (
        .tx_clk   (tx_clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .tx_valid (tx_valid),
        .data_in  (tx_data),
        .tx_ready (tx_ready)
    );

    cdc_handshake #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_cdc (
        .rst_n    (rst_n),
        .tx_clk   (tx_clk),
        .rx_clk   (rx_clk),
        .tx_valid (tx_valid),
        .data_in  (tx_data),
        .tx_ready (tx_ready),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .data_out (rx_data)
    );

    rx_word_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .rx_clk    (rx_clk),
        .rst_n     (rst_n),
        .in_valid  (rx_valid),
        .in_data   (rx_data),
        .in_ready  (rx_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

/* bench/tb_mailbox_bridge.sv */
`timescale 1ns/1ns

module tb_mailbox_bridge;

    localparam int DATA_WIDTH    = 32;
    localparam int FIFO_DEPTH    = 4;
    localparam int SEED          = 70424;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_RANDOM    = 60;
    localparam int HOLD_POLLS    = 20;
    localparam int ACK_TIMEOUT   = 20;
    localparam int BUSY_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 200;
    localparam logic [31:0] DROPPED_WORD = 32'h0bad_f00d;

    logic                                    tx_clk = 1'b0;
    logic                                    rx_clk = 1'b0;
    logic                                    rst_n;
    logic                                    wb_cyc;
    logic                                    wb_stb;
    logic                                    wb_we;
    logic [bridge_bus_pkg::WB_ADR_WIDTH-1:0] wb_adr;
    logic [31:0]                             wb_dat_w;
    logic                                    wb_ack;
    logic [31:0]                             wb_dat_r;
    logic                                    out_valid;
    logic [DATA_WIDTH-1:0]                   out_data;
    logic                                    out_ready;

    integer      data_seed  = SEED;
    integer      ready_seed = SEED;
    int          ready_mode = 0;  // 0 holds out_ready low, 1 random, 2 high
    logic [31:0] exp_q[$];        // Words the mailbox accepted, oldest first
    logic [31:0] expected_word;
    logic [31:0] ready_rnd;

    always #5 rx_clk = ~rx_clk;
    always #7 tx_clk = ~tx_clk;  // Unrelated period keeps the two domains drifting

    mailbox_bridge_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .tx_clk    (tx_clk),
        .rx_clk    (rx_clk),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            fail_run("A checked value did not match the model");
        end
    endtask

    function automatic logic [31:0] status_word(input logic busy, input logic ovf);
        logic [31:0] word;
        word = '0;
        word[bridge_bus_pkg::STATUS_BUSY_BIT] = busy;
        word[bridge_bus_pkg::STATUS_OVF_BIT]  = ovf;
        return word;
    endfunction

    task automatic align_tx();
        @(posedge tx_clk);
        #1;
    endtask

    task automatic idle_tx(input int cycles);
        repeat (cycles) align_tx();
    endtask

    task automatic wait_wb_ack();
        int cycles;
        cycles = 0;
        do begin
            align_tx();
            cycles++;
            if (!wb_ack && cycles > ACK_TIMEOUT) begin
                fail_run("Wishbone ack did not arrive in time");
            end
        end while (!wb_ack);
    endtask

    task automatic wb_write(input bridge_bus_pkg::reg_addr_e addr, input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        wait_wb_ack();
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
    endtask

    task automatic wb_read(input bridge_bus_pkg::reg_addr_e addr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        wait_wb_ack();
        data   = wb_dat_r;  // Registered together with the ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wait_idle(output logic [31:0] status);
        int polls;
        polls = 0;
        wb_read(bridge_bus_pkg::REG_STATUS, status);
        while (status[bridge_bus_pkg::STATUS_BUSY_BIT]) begin
            polls++;
            if (polls > BUSY_TIMEOUT) begin
                fail_run("Mailbox stayed busy and never finished its transfer");
            end
            wb_read(bridge_bus_pkg::REG_STATUS, status);
        end
    endtask

    task automatic wait_queue_empty();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge rx_clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                fail_run("Accepted words never reached the output stream");
            end
        end
    endtask

    task automatic send_word(input logic [31:0] word);
        wb_write(bridge_bus_pkg::REG_DATA, word);
        exp_q.push_back(word);
    endtask

    // The consumer changes out_ready 1 ns after each rx_clk edge
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge rx_clk);
            #1;
            ready_rnd = $random(ready_seed);
            case (ready_mode)
                0: out_ready = 1'b0;
                1: out_ready = ready_rnd[0];
                default: out_ready = 1'b1;
            endcase
        end
    end

    // All stream signals are settled at the falling edge, the transfer happens on the next rise
    always @(negedge rx_clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("A word left the FIFO although the model expected none");
            end
            expected_word = exp_q.pop_front();
            check_value("out_data", 32'(out_data), expected_word);
        end
    end

    initial begin
        #2_000_000;
        fail_run("Simulation ran past its time limit");
    end

    initial begin : main_seq
        logic [31:0] status;
        logic [31:0] rd_val;
        logic [31:0] rnd;
        int          accepted;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        accepted = 0;
        repeat (RESET_CYCLES) @(posedge rx_clk);
        #1;
        rst_n = 1'b1;
        align_tx();

        check_value("out_valid", 32'(out_valid), 32'd0);
        wb_read(bridge_bus_pkg::REG_STATUS, status);
        check_value("STATUS", status, status_word(1'b0, 1'b0));
        wb_read(bridge_bus_pkg::REG_COUNT, rd_val);
        check_value("COUNT", rd_val, 32'd0);

        // FIFO_DEPTH words fill the FIFO, one more sticks in the crossing
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            wait_idle(status);
            rnd = $random(data_seed);
            send_word(rnd);
            accepted++;
        end
        for (int i = 0; i < HOLD_POLLS; i++) begin
            wb_read(bridge_bus_pkg::REG_STATUS, status);
            check_value("STATUS", status, status_word(1'b1, 1'b0));
        end
        wb_write(bridge_bus_pkg::REG_DATA, DROPPED_WORD);
        wb_read(bridge_bus_pkg::REG_STATUS, status);
        check_value("STATUS", status, status_word(1'b1, 1'b1));
        wb_write(bridge_bus_pkg::REG_CTRL, 32'd1);
        wb_read(bridge_bus_pkg::REG_STATUS, status);
        check_value("STATUS", status, status_word(1'b1, 1'b0));
        wb_read(bridge_bus_pkg::REG_COUNT, rd_val);
        check_value("COUNT", rd_val, 32'(accepted));

        ready_mode = 1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(data_seed);
            idle_tx(int'(rnd[2:0]));
            wb_read(bridge_bus_pkg::REG_STATUS, status);
            check_value("STATUS.overflow", 32'(status[bridge_bus_pkg::STATUS_OVF_BIT]), 32'd0);
            if (!status[bridge_bus_pkg::STATUS_BUSY_BIT]) begin
                rnd = $random(data_seed);
                send_word(rnd);
                accepted++;
            end
        end
        wb_read(bridge_bus_pkg::REG_COUNT, rd_val);
        check_value("COUNT", rd_val, 32'(accepted));

        ready_mode = 2;
        wait_idle(status);
        wait_queue_empty();
        @(posedge rx_clk);
        #1;
        check_value("out_valid", 32'(out_valid), 32'd0);
        align_tx();
        wb_read(bridge_bus_pkg::REG_COUNT, rd_val);
        check_value("COUNT", rd_val, 32'(accepted));

        $display("All tests passed");
        $finish;
    end

endmodule

/* filelist.f */
src/bridge_bus_pkg.sv
src/bridge_link_pkg.sv
src/wb_mailbox_regs.sv
src/cdc_handshake.sv
src/rx_word_fifo.sv
src/mailbox_bridge_top.sv
bench/tb_mailbox_bridge.sv

/* run.sh */
#!/bin/sh
# Builds the mailbox bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mailbox_bridge \
    -f filelist.f \
    -o sim_mailbox_bridge
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_mailbox_bridge
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
